//--- Bender.yml
package:
  name: rv_decode_stage

sources:
  - files:
      - rv_decode_pkg.sv
      - decode_ifs.sv
      - instr_field_decoder.sv
      - control_unit.sv
      - register_file.sv
      - decode_issue.sv
      - decode_stage.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_decode_stage.sv

//--- control_unit.sv
`timescale 1ns/100ps

module control_unit (
  input  rv_decode_pkg::instr_t instr,
  decode_ctrl_if.producer       ctrl
);

  import rv_decode_pkg::*;

  opcode_t opcode;
  funct3_t funct3;

  // funct3 legality per class
  logic load_f3_ok;
  logic store_f3_ok;
  logic branch_f3_ok;
  logic illegal;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];

  // 011, 110 and 111 have no rv32i load
  assign load_f3_ok = (funct3 == F3_LB) || (funct3 == F3_LH) || (funct3 == F3_LW) ||
                      (funct3 == F3_LBU) || (funct3 == F3_LHU);
  assign store_f3_ok = (funct3 == F3_SB) || (funct3 == F3_SH) || (funct3 == F3_SW);
  assign branch_f3_ok = (funct3 == F3_BEQ) || (funct3 == F3_BNE) || (funct3 == F3_BLT) ||
                        (funct3 == F3_BGE) || (funct3 == F3_BLTU) || (funct3 == F3_BGEU);

  always_comb begin
    case (opcode)
      OPC_LUI, OPC_AUIPC, OPC_OP_IMM, OPC_OP, OPC_JAL, OPC_JALR: illegal = 1'b0;
      OPC_LOAD:   illegal = !load_f3_ok;
      OPC_STORE:  illegal = !store_f3_ok;
      OPC_BRANCH: illegal = !branch_f3_ok;
      // fence, system, csr and anything else
      default:    illegal = 1'b1;
    endcase
  end

  always_comb begin
    ctrl.reg_write  = 1'b0;
    ctrl.mem_write  = 1'b0;
    ctrl.branch     = 1'b0;
    ctrl.jump       = 1'b0;
    ctrl.result_src = RES_ALU;
    ctrl.alu_src_b  = SRC_B_IMM;
    case (opcode)
      OPC_LUI, OPC_AUIPC, OPC_OP_IMM: ctrl.reg_write = 1'b1;
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src_b = SRC_B_REG;
      end
      OPC_JAL, OPC_JALR: begin
        // link value is pc + 4, target comes from the alu
        ctrl.reg_write  = 1'b1;
        ctrl.jump       = 1'b1;
        ctrl.result_src = RES_PC_PLUS_4;
      end
      OPC_LOAD: begin
        ctrl.reg_write  = 1'b1;
        ctrl.result_src = RES_MEM;
      end
      OPC_STORE: ctrl.mem_write = 1'b1;
      OPC_BRANCH: begin
        // both operands from registers for the compare
        ctrl.branch    = 1'b1;
        ctrl.alu_src_b = SRC_B_REG;
      end
      default: ctrl.alu_src_b = SRC_B_REG;
    endcase
    // an illegal op must not change architectural state
    if (illegal) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_write = 1'b0;
    end
    ctrl.illegal = illegal;
  end

  // no opcode both writes memory and a register
  always_comb begin
    a_no_dual_write: assert final ($isunknown(instr) || !(ctrl.reg_write && ctrl.mem_write))
      else $error("reg_write and mem_write both set for instr %h", instr);
  end

endmodule

//--- decode_ifs.sv
`timescale 1ns/100ps

// field decoder results toward the issue stage
interface decode_fields_if;

  import rv_decode_pkg::*;

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  imm_t     imm;
  alu_op_t  alu_op;

  modport producer (output rs1, rs2, rd, imm, alu_op);
  modport consumer (input  rs1, rs2, rd, imm, alu_op);

endinterface

// main control bits toward the issue stage
interface decode_ctrl_if;

  import rv_decode_pkg::*;

  logic        reg_write;
  logic        mem_write;
  logic        branch;
  logic        jump;
  result_src_t result_src;
  alu_src_b_t  alu_src_b;
  logic        illegal;

  modport producer (output reg_write, mem_write, branch, jump, result_src, alu_src_b, illegal);
  modport consumer (input  reg_write, mem_write, branch, jump, result_src, alu_src_b, illegal);

endinterface

//--- decode_issue.sv
`timescale 1ns/100ps

module decode_issue (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       if_valid,
  input  rv_decode_pkg::instr_t      if_instr,
  input  rv_decode_pkg::addr_t       if_pc,
  output logic                       fetch_credit,
  output rv_decode_pkg::instr_t      slot_instr,
  decode_fields_if.consumer          fields,
  decode_ctrl_if.consumer            ctrl,
  input  rv_decode_pkg::data_t       rs1_data,
  input  rv_decode_pkg::data_t       rs2_data,
  input  logic                       ex_credit,
  output logic                       ex_valid,
  output rv_decode_pkg::addr_t       ex_pc,
  output rv_decode_pkg::reg_idx_t    ex_rs1,
  output rv_decode_pkg::reg_idx_t    ex_rs2,
  output rv_decode_pkg::reg_idx_t    ex_rd,
  output rv_decode_pkg::data_t       ex_rs1_data,
  output rv_decode_pkg::data_t       ex_rs2_data,
  output rv_decode_pkg::imm_t        ex_imm,
  output rv_decode_pkg::alu_op_t     ex_alu_op,
  output rv_decode_pkg::alu_src_b_t  ex_alu_src_b,
  output rv_decode_pkg::result_src_t ex_result_src,
  output logic                       ex_reg_write,
  output logic                       ex_mem_write,
  output logic                       ex_branch,
  output logic                       ex_jump,
  output logic                       ex_illegal
);

  import rv_decode_pkg::*;

  slot_state_t slot_state;
  addr_t       slot_pc;
  credit_t     credit_cnt;
  logic        issue;

  // slot drains whenever execute has room
  assign issue = (slot_state == SLOT_FULL) && (credit_cnt != '0);

  // the freed slot goes straight back to fetch in the same cycle
  assign fetch_credit = issue;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot_state <= SLOT_EMPTY;
    end else if (if_valid) begin
      slot_state <= SLOT_FULL;
    end else if (issue) begin
      slot_state <= SLOT_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid) begin
      slot_instr <= if_instr;
      slot_pc    <= if_pc;
    end
  end

  // return and issue together cancel out
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_cnt <= credit_t'(EX_CREDITS);
    end else if (issue && !ex_credit) begin
      credit_cnt <= credit_cnt - credit_t'(1);
    end else if (!issue && ex_credit) begin
      credit_cnt <= credit_cnt + credit_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= issue;
    end
  end

  // bundle held until the next issue
  always_ff @(posedge clk) begin
    if (issue) begin
      ex_pc         <= slot_pc;
      ex_rs1        <= fields.rs1;
      ex_rs2        <= fields.rs2;
      ex_rd         <= fields.rd;
      ex_rs1_data   <= rs1_data;
      ex_rs2_data   <= rs2_data;
      ex_imm        <= fields.imm;
      ex_alu_op     <= fields.alu_op;
      ex_alu_src_b  <= ctrl.alu_src_b;
      ex_result_src <= ctrl.result_src;
      ex_reg_write  <= ctrl.reg_write;
      ex_mem_write  <= ctrl.mem_write;
      ex_branch     <= ctrl.branch;
      ex_jump       <= ctrl.jump;
      ex_illegal    <= ctrl.illegal;
    end
  end

  // fetch only sends into an empty slot or one draining this cycle
  a_no_slot_overrun: assert property (@(posedge clk) disable iff (!rst_n)
    if_valid |-> (slot_state == SLOT_EMPTY) || issue)
    else $error("if_valid while the input slot is full");

  // execute never returns more credits than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= credit_t'(EX_CREDITS))
    else $error("execute credit counter above EX_CREDITS");

endmodule

//--- decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       if_valid,
  input  rv_decode_pkg::instr_t      if_instr,
  input  rv_decode_pkg::addr_t       if_pc,
  output logic                       fetch_credit,
  input  logic                       wb_we,
  input  rv_decode_pkg::reg_idx_t    wb_rd,
  input  rv_decode_pkg::data_t       wb_data,
  input  logic                       ex_credit,
  output logic                       ex_valid,
  output rv_decode_pkg::addr_t       ex_pc,
  output rv_decode_pkg::reg_idx_t    ex_rs1,
  output rv_decode_pkg::reg_idx_t    ex_rs2,
  output rv_decode_pkg::reg_idx_t    ex_rd,
  output rv_decode_pkg::data_t       ex_rs1_data,
  output rv_decode_pkg::data_t       ex_rs2_data,
  output rv_decode_pkg::imm_t        ex_imm,
  output rv_decode_pkg::alu_op_t     ex_alu_op,
  output rv_decode_pkg::alu_src_b_t  ex_alu_src_b,
  output rv_decode_pkg::result_src_t ex_result_src,
  output logic                       ex_reg_write,
  output logic                       ex_mem_write,
  output logic                       ex_branch,
  output logic                       ex_jump,
  output logic                       ex_illegal
);

  import rv_decode_pkg::*;

  // instruction held in the input slot, read by decoder and control
  instr_t slot_instr;
  data_t  rs1_data;
  data_t  rs2_data;

  decode_fields_if fields_if ();
  decode_ctrl_if   ctrl_if ();

  instr_field_decoder u_fields (
    .instr  (slot_instr),
    .fields (fields_if.producer)
  );

  control_unit u_ctrl (
    .instr (slot_instr),
    .ctrl  (ctrl_if.producer)
  );

  // read ports addressed straight from the decoded indices
  register_file u_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .rs1   (fields_if.rs1),
    .rs2   (fields_if.rs2),
    .rd1   (rs1_data),
    .rd2   (rs2_data),
    .we    (wb_we),
    .wa    (wb_rd),
    .wd    (wb_data)
  );

  decode_issue u_issue (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_valid      (if_valid),
    .if_instr      (if_instr),
    .if_pc         (if_pc),
    .fetch_credit  (fetch_credit),
    .slot_instr    (slot_instr),
    .fields        (fields_if.consumer),
    .ctrl          (ctrl_if.consumer),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .ex_credit     (ex_credit),
    .ex_valid      (ex_valid),
    .ex_pc         (ex_pc),
    .ex_rs1        (ex_rs1),
    .ex_rs2        (ex_rs2),
    .ex_rd         (ex_rd),
    .ex_rs1_data   (ex_rs1_data),
    .ex_rs2_data   (ex_rs2_data),
    .ex_imm        (ex_imm),
    .ex_alu_op     (ex_alu_op),
    .ex_alu_src_b  (ex_alu_src_b),
    .ex_result_src (ex_result_src),
    .ex_reg_write  (ex_reg_write),
    .ex_mem_write  (ex_mem_write),
    .ex_branch     (ex_branch),
    .ex_jump       (ex_jump),
    .ex_illegal    (ex_illegal)
  );

endmodule

//--- instr_field_decoder.sv
`timescale 1ns/100ps

module instr_field_decoder (
  input  rv_decode_pkg::instr_t instr,
  decode_fields_if.producer     fields
);

  import rv_decode_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;

  // immediates of every format, the opcode picks one
  imm_t imm_i;
  imm_t imm_s;
  imm_t imm_b;
  imm_t imm_u;
  imm_t imm_j;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // sign bit is always instr[31]
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  // branch and jump offsets are in halfwords, bit 0 forced low
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // source indices sit at fixed bit positions in all formats
  assign fields.rs1 = instr[19:15];
  assign fields.rs2 = instr[24:20];

  // stores and branches keep immediate bits where rd would be
  assign fields.rd = (opcode == OPC_STORE || opcode == OPC_BRANCH) ? '0 : instr[11:7];

  always_comb begin
    case (opcode)
      OPC_LOAD, OPC_JALR, OPC_OP_IMM: fields.imm = imm_i;
      OPC_STORE:                      fields.imm = imm_s;
      OPC_BRANCH:                     fields.imm = imm_b;
      OPC_LUI, OPC_AUIPC:             fields.imm = imm_u;
      OPC_JAL:                        fields.imm = imm_j;
      // register-register ops and unknown opcodes
      default:                        fields.imm = '0;
    endcase
  end

  always_comb begin
    // address adds for loads, stores, jumps and auipc
    fields.alu_op = ALU_ADD;
    case (opcode)
      OPC_LUI: fields.alu_op = ALU_PASS_B;
      OPC_BRANCH: begin
        // execute derives the taken flag from the compare result
        case (funct3)
          F3_BEQ, F3_BNE:   fields.alu_op = ALU_SUB;
          F3_BLT, F3_BGE:   fields.alu_op = ALU_SLT;
          F3_BLTU, F3_BGEU: fields.alu_op = ALU_SLTU;
          default:          fields.alu_op = ALU_SUB;
        endcase
      end
      OPC_OP_IMM, OPC_OP: begin
        case (funct3)
          // no subi, so the alternate form only counts for op
          F3_ADD_SUB: fields.alu_op = (opcode == OPC_OP && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          F3_SLL:     fields.alu_op = ALU_SLL;
          F3_SLT:     fields.alu_op = ALU_SLT;
          F3_SLTU:    fields.alu_op = ALU_SLTU;
          F3_XOR:     fields.alu_op = ALU_XOR;
          // srai keeps the same funct7 bits in imm[11:5]
          F3_SRL_SRA: fields.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          F3_OR:      fields.alu_op = ALU_OR;
          default:    fields.alu_op = ALU_AND;
        endcase
      end
      default: fields.alu_op = ALU_ADD;
    endcase
  end

  // every known instruction word maps to a defined alu operation
  always_comb begin
    a_alu_op_known: assert final ($isunknown(instr) || !$isunknown(fields.alu_op))
      else $error("alu_op unknown for instr %h", instr);
  end

endmodule

//--- register_file.sv
`timescale 1ns/100ps

module register_file (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rv_decode_pkg::reg_idx_t rs1,
  input  rv_decode_pkg::reg_idx_t rs2,
  output rv_decode_pkg::data_t    rd1,
  output rv_decode_pkg::data_t    rd2,
  input  logic                    we,
  input  rv_decode_pkg::reg_idx_t wa,
  input  rv_decode_pkg::data_t    wd
);

  import rv_decode_pkg::*;

  // x0 has no storage
  data_t regs [NUM_REGS-1:1];

  // write enable with x0 filtered out
  logic wr_en;

  // same-cycle write hits per read port
  logic bypass1;
  logic bypass2;

  assign wr_en = we && (wa != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wa] <= wd;
    end
  end

  assign bypass1 = wr_en && (wa == rs1);
  assign bypass2 = wr_en && (wa == rs2);

  // asynchronous reads, x0 first, then the writeback value, then storage
  assign rd1 = (rs1 == '0) ? '0 : (bypass1 ? wd : regs[rs1]);
  assign rd2 = (rs2 == '0) ? '0 : (bypass2 ? wd : regs[rs2]);

endmodule

//--- rv_decode_pkg.sv
package rv_decode_pkg;

  // datapath widths
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;

  // execute input queue depth, as seen by the decode credit counter
  localparam int EX_CREDITS = 2;
  localparam int CREDIT_W   = 2;

  typedef logic [XLEN-1:0]      instr_t;
  typedef logic [XLEN-1:0]      addr_t;
  typedef logic [XLEN-1:0]      data_t;
  typedef logic [XLEN-1:0]      imm_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [2:0]           funct3_t;
  typedef logic [6:0]           funct7_t;
  typedef logic [CREDIT_W-1:0]  credit_t;

  // rv32i major opcodes handled by this stage
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_t;

  // what writeback takes as the rd value
  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC_PLUS_4} result_src_t;

  typedef enum logic {SRC_B_REG, SRC_B_IMM} alu_src_b_t;

  // input slot occupancy
  typedef enum logic {SLOT_EMPTY, SLOT_FULL} slot_state_t;

  // funct3 of register and immediate arithmetic
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // funct3 of branches
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // funct3 of loads and stores, byte, half and word
  localparam funct3_t F3_LB  = 3'b000;
  localparam funct3_t F3_LH  = 3'b001;
  localparam funct3_t F3_LW  = 3'b010;
  localparam funct3_t F3_LBU = 3'b100;
  localparam funct3_t F3_LHU = 3'b101;
  localparam funct3_t F3_SB  = 3'b000;
  localparam funct3_t F3_SH  = 3'b001;
  localparam funct3_t F3_SW  = 3'b010;

  // funct7 that selects sub and sra
  localparam funct7_t F7_ALT = 7'b0100000;

endpackage

//--- sources.f
rv_decode_pkg.sv
decode_ifs.sv
instr_field_decoder.sv
control_unit.sv
register_file.sv
decode_issue.sv
decode_stage.sv
tb_clock_gen.sv
tb_decode_stage.sv

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset released a little after the edge that ends the reset window
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

//--- tb_decode_stage.sv
`timescale 1ns/100ps

module tb_decode_stage;

  import rv_decode_pkg::*;

  localparam int TIMEOUT = 300;
  localparam logic [6:0] ALT = 7'b0100000;

  // expected ex_ bundle
  typedef struct packed {
    addr_t       pc;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    data_t       rs1_data;
    data_t       rs2_data;
    imm_t        imm;
    logic [3:0]  alu_op;
    logic        alu_src_b;
    logic [1:0]  result_src;
    logic        reg_write;
    logic        mem_write;
    logic        branch;
    logic        jump;
    logic        illegal;
  } bundle_t;

  logic        clk;
  logic        rst_n;
  logic        if_valid;
  instr_t      if_instr;
  addr_t       if_pc;
  logic        fetch_credit;
  logic        wb_we;
  reg_idx_t    wb_rd;
  data_t       wb_data;
  logic        ex_credit;
  logic        ex_valid;
  addr_t       ex_pc;
  reg_idx_t    ex_rs1;
  reg_idx_t    ex_rs2;
  reg_idx_t    ex_rd;
  data_t       ex_rs1_data;
  data_t       ex_rs2_data;
  imm_t        ex_imm;
  alu_op_t     ex_alu_op;
  alu_src_b_t  ex_alu_src_b;
  result_src_t ex_result_src;
  logic        ex_reg_write;
  logic        ex_mem_write;
  logic        ex_branch;
  logic        ex_jump;
  logic        ex_illegal;

  // testbench state
  logic [31:0] lfsr_state = 32'hbd85;
  data_t       mirror [0:31];
  instr_t      sent_instr [$];
  addr_t       sent_pc [$];
  int          sent_cyc [$];
  int          cyc;
  int          errors;
  int          fetch_credits;
  int          ex_occupancy;
  int          drain_wait;
  bit          slow_drain;
  bit          check_latency;
  bit          timed_out;
  int          tests_run;
  int          tests_failed;
  addr_t       next_pc;

  tb_clock_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  decode_stage dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_valid      (if_valid),
    .if_instr      (if_instr),
    .if_pc         (if_pc),
    .fetch_credit  (fetch_credit),
    .wb_we         (wb_we),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .ex_credit     (ex_credit),
    .ex_valid      (ex_valid),
    .ex_pc         (ex_pc),
    .ex_rs1        (ex_rs1),
    .ex_rs2        (ex_rs2),
    .ex_rd         (ex_rd),
    .ex_rs1_data   (ex_rs1_data),
    .ex_rs2_data   (ex_rs2_data),
    .ex_imm        (ex_imm),
    .ex_alu_op     (ex_alu_op),
    .ex_alu_src_b  (ex_alu_src_b),
    .ex_result_src (ex_result_src),
    .ex_reg_write  (ex_reg_write),
    .ex_mem_write  (ex_mem_write),
    .ex_branch     (ex_branch),
    .ex_jump       (ex_jump),
    .ex_illegal    (ex_illegal)
  );

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // register and immediate arithmetic, sub only for the register form
  function automatic logic [3:0] arith_op(input logic [2:0] f3, input logic [6:0] f7,
                                          input logic is_op);
    case (f3)
      3'd0:    return (is_op && f7 == ALT) ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return (f7 == ALT) ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic bundle_t ref_bundle(input instr_t ins, input addr_t pc);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    bundle_t    b;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    b = '0;
    b.pc  = pc;
    b.rs1 = ins[19:15];
    b.rs2 = ins[24:20];
    b.rd  = (opc == OPC_STORE || opc == OPC_BRANCH) ? 5'd0 : ins[11:7];
    b.rs1_data   = mirror[b.rs1];
    b.rs2_data   = mirror[b.rs2];
    b.alu_op     = ALU_ADD;
    b.alu_src_b  = SRC_B_IMM;
    b.result_src = RES_ALU;
    case (opc)
      OPC_LUI: begin
        b.reg_write = 1'b1;
        b.alu_op    = ALU_PASS_B;
        b.imm       = {ins[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        b.reg_write = 1'b1;
        b.imm       = {ins[31:12], 12'b0};
      end
      OPC_JAL: begin
        b.reg_write  = 1'b1;
        b.jump       = 1'b1;
        b.result_src = RES_PC_PLUS_4;
        b.imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      OPC_JALR: begin
        b.reg_write  = 1'b1;
        b.jump       = 1'b1;
        b.result_src = RES_PC_PLUS_4;
        b.imm = {{20{ins[31]}}, ins[31:20]};
      end
      OPC_LOAD: begin
        b.reg_write  = 1'b1;
        b.result_src = RES_MEM;
        b.imm        = {{20{ins[31]}}, ins[31:20]};
        // lb lh lw lbu lhu only
        b.illegal = (f3 == 3'd3) || (f3 == 3'd6) || (f3 == 3'd7);
      end
      OPC_STORE: begin
        b.mem_write = 1'b1;
        b.imm       = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        b.illegal   = (f3 > 3'd2);
      end
      OPC_BRANCH: begin
        b.branch    = 1'b1;
        b.alu_src_b = SRC_B_REG;
        b.imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        b.illegal = (f3 == 3'd2) || (f3 == 3'd3);
        if (f3 == 3'd4 || f3 == 3'd5) begin
          b.alu_op = ALU_SLT;
        end else if (f3 == 3'd6 || f3 == 3'd7) begin
          b.alu_op = ALU_SLTU;
        end else begin
          b.alu_op = ALU_SUB;
        end
      end
      OPC_OP_IMM: begin
        b.reg_write = 1'b1;
        b.imm       = {{20{ins[31]}}, ins[31:20]};
        b.alu_op    = arith_op(f3, f7, 1'b0);
      end
      OPC_OP: begin
        b.reg_write = 1'b1;
        b.alu_src_b = SRC_B_REG;
        b.alu_op    = arith_op(f3, f7, 1'b1);
      end
      default: begin
        b.illegal   = 1'b1;
        b.alu_src_b = SRC_B_REG;
      end
    endcase
    if (b.illegal) begin
      b.reg_write = 1'b0;
      b.mem_write = 1'b0;
    end
    return b;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // legal instruction of a random class, other fields random
  function automatic instr_t rand_instr();
    logic [6:0] opcodes [0:8];
    logic [6:0] opc;
    instr_t     ins;
    opcodes = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};
    opc = opcodes[rand_bits(4) % 9];
    ins = {25'(rand_bits(25)), opc};
    // shifts and register ops carry either funct7 form
    if (opc == OPC_OP || (opc == OPC_OP_IMM && ins[13:12] == 2'b01)) begin
      ins[31:25] = rand_bits(1) ? ALT : 7'b0;
    end
    return ins;
  endfunction

  // fetch model, one credit back per fetch_credit pulse
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (rst_n && fetch_credit) begin
      fetch_credits++;
    end
  end

  task automatic send(input instr_t ins);
    int t;
    t = 0;
    // a credit returned during this cycle can be spent at the next edge
    while (fetch_credits == 0 && !fetch_credit) begin
      @(posedge clk);
      #1;
      t++;
      if (t > TIMEOUT) begin
        $display("timeout waiting for a fetch credit");
        timed_out = 1'b1;
        return;
      end
    end
    // back-to-back traffic never waits for the slot
    if (check_latency) begin
      check("fetch wait cycles", t, 0);
    end
    fetch_credits--;
    if_valid = 1'b1;
    if_instr = ins;
    if_pc    = next_pc;
    sent_instr.push_back(ins);
    sent_pc.push_back(next_pc);
    sent_cyc.push_back(cyc);
    next_pc = next_pc + 32'd4;
    @(posedge clk);
    #1;
    if_valid = 1'b0;
  endtask

  task automatic writeback(input reg_idx_t idx, input data_t data);
    wb_we   = 1'b1;
    wb_rd   = idx;
    wb_data = data;
    if (idx != 5'd0) begin
      mirror[idx] = data;
    end
    @(posedge clk);
    #1;
    wb_we = 1'b0;
  endtask

  // all sent instructions compared and every execute credit returned
  task automatic drain();
    int t;
    t = 0;
    while (sent_instr.size() != 0 || ex_occupancy != 0) begin
      @(posedge clk);
      #1;
      t++;
      if (t > TIMEOUT) begin
        $display("timeout waiting for issued instructions to drain through execute");
        timed_out = 1'b1;
        return;
      end
    end
  endtask

  // execute model, drives ex_credit 2 ns after the edge
  initial begin
    forever begin
      @(posedge clk);
      #2;
      ex_credit = 1'b0;
      if (rst_n) begin
        if (ex_valid) begin
          if (ex_occupancy >= EX_CREDITS) begin
            $display("execute queue overrun: ex_valid without a free credit at %0t", $time);
            errors++;
          end else begin
            ex_occupancy++;
          end
        end
        if (ex_occupancy > 0) begin
          if (drain_wait == 0) begin
            ex_credit = 1'b1;
            ex_occupancy--;
            drain_wait = slow_drain ? int'(rand_bits(3)) + 1 : 0;
          end else begin
            drain_wait--;
          end
        end
      end
    end
  end

  // compare process, samples the bundle mid-cycle
  always @(negedge clk) begin
    bundle_t e;
    instr_t  ins;
    if (rst_n && ex_valid) begin
      if (sent_instr.size() == 0) begin
        $display("ex_valid at %0t with no instruction outstanding", $time);
        errors++;
      end else begin
        ins = sent_instr.pop_front();
        e = ref_bundle(ins, sent_pc.pop_front());
        if (check_latency) begin
          check("latency", cyc - sent_cyc.pop_front(), 2);
        end else begin
          void'(sent_cyc.pop_front());
        end
        check("pc", ex_pc, e.pc);
        check("rs1", ex_rs1, e.rs1);
        check("rs2", ex_rs2, e.rs2);
        check("rd", ex_rd, e.rd);
        check("rs1_data", ex_rs1_data, e.rs1_data);
        check("rs2_data", ex_rs2_data, e.rs2_data);
        check("imm", ex_imm, e.imm);
        check("alu_op", ex_alu_op, e.alu_op);
        check("alu_src_b", ex_alu_src_b, e.alu_src_b);
        check("result_src", ex_result_src, e.result_src);
        check("reg_write", ex_reg_write, e.reg_write);
        check("mem_write", ex_mem_write, e.mem_write);
        check("branch", ex_branch, e.branch);
        check("jump", ex_jump, e.jump);
        check("illegal", ex_illegal, e.illegal);
      end
    end
  end

  task automatic report(input string name, input int errors_before);
    tests_run++;
    if (errors != errors_before || timed_out) begin
      tests_failed++;
    end
    $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
  endtask

  initial begin
    int         e0;
    int         t;
    instr_t     ins;
    logic [6:0] bad_opc [0:3];
    if_valid      = 1'b0;
    if_instr      = '0;
    if_pc         = '0;
    wb_we         = 1'b0;
    wb_rd         = '0;
    wb_data       = '0;
    ex_credit     = 1'b0;
    cyc           = 0;
    errors        = 0;
    fetch_credits = 1;
    ex_occupancy  = 0;
    drain_wait    = 0;
    slow_drain    = 1'b0;
    check_latency = 1'b0;
    timed_out     = 1'b0;
    tests_run     = 0;
    tests_failed  = 0;
    next_pc       = 32'h0000_1000;
    bad_opc       = '{7'b0001111, 7'b1110011, 7'b0000000, 7'b1111111};
    for (int i = 0; i < 32; i++) begin
      mirror[i] = '0;
    end

    t = 0;
    while (!rst_n && !timed_out) begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) begin
        $display("timeout waiting for reset release");
        timed_out = 1'b1;
      end
    end
    @(negedge clk);

    // registers all read zero straight out of reset
    e0 = errors;
    check("ex_valid after reset", ex_valid, 1'b0);
    check("fetch_credit after reset", fetch_credit, 1'b0);
    @(posedge clk);
    #1;
    for (int i = 0; i < 16 && !timed_out; i++) begin
      send({7'b0, 5'(2 * i + 1), 5'(2 * i), 3'b000, 5'(i), OPC_OP});
    end
    drain();
    report("reset state", e0);

    if (!timed_out) begin
      e0 = errors;
      for (int i = 0; i < 32; i++) begin
        writeback(5'(i), rand_bits(32));
      end
      for (int i = 0; i < 60 && !timed_out; i++) begin
        send(rand_instr());
      end
      drain();
      report("field decode", e0);
    end

    // write lands in the same cycle as the slot read
    if (!timed_out) begin
      e0 = errors;
      for (int i = 0; i < 6 && !timed_out; i++) begin
        ins = {7'b0, 5'(i + 10), 5'(i + 3), 3'b000, 5'd1, OPC_OP};
        send(ins);
        writeback(ins[19:15], rand_bits(32));
        drain();
      end
      report("writeback bypass", e0);
    end

    if (!timed_out) begin
      e0 = errors;
      slow_drain = 1'b1;
      for (int i = 0; i < 40 && !timed_out; i++) begin
        send(rand_instr());
      end
      drain();
      slow_drain = 1'b0;
      drain_wait = 0;
      report("execute back-pressure", e0);
    end

    if (!timed_out) begin
      e0 = errors;
      check_latency = 1'b1;
      for (int i = 0; i < 30 && !timed_out; i++) begin
        send(rand_instr());
      end
      drain();
      check_latency = 1'b0;
      report("back-to-back issue", e0);
    end

    if (!timed_out) begin
      e0 = errors;
      for (int i = 0; i < 4 && !timed_out; i++) begin
        send({25'(rand_bits(25)), bad_opc[i]});
      end
      for (int f = 3; f < 8 && !timed_out; f++) begin
        send({17'(rand_bits(17)), 3'(f), 5'(rand_bits(5)), OPC_STORE});
      end
      send({17'(rand_bits(17)), 3'd3, 5'(rand_bits(5)), OPC_LOAD});
      send({17'(rand_bits(17)), 3'd6, 5'(rand_bits(5)), OPC_LOAD});
      send({17'(rand_bits(17)), 3'd7, 5'(rand_bits(5)), OPC_LOAD});
      send({17'(rand_bits(17)), 3'd2, 5'(rand_bits(5)), OPC_BRANCH});
      send({17'(rand_bits(17)), 3'd3, 5'(rand_bits(5)), OPC_BRANCH});
      drain();
      report("illegal instructions", e0);
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
